// ==== Makefile ====
# Verilator build and run for the bus subsystem

VERILATOR  ?= verilator
TOP        ?= tb_bus_subsystem
RTL_TOP    ?= bus_subsystem_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --timing -Wall
PASS_MSG   ?= Test completed successfully

SOURCES := $(wildcard hw/*.sv dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_bus_subsystem.sv ====
module tb_bus_subsystem import bus_pkg::*; ();

   // wait counts handed to the DUT
   localparam int mem_wait = 2;
   localparam int io_wait  = 0;

   localparam int half_period = 20;
   localparam int max_rows    = 32;
   // idle cycles watched after a row that pokes cmd_valid while busy
   localparam int poke_gap    = 3;

   logic              clk;
   logic              rst_n;
   logic              nhalt;
   logic              cmd_valid;
   bus_op_e           cmd_op;
   logic [addr_w-1:0] cmd_addr;
   logic [data_w-1:0] cmd_wdata;
   logic              busy;
   logic              done;
   logic [data_w-1:0] rdata;

   ////////////////////////////////////////////////////////////////////
   // stimulus table and shadow storage
   ////////////////////////////////////////////////////////////////////

   // one row per bus command
   bus_op_e           tbl_op   [max_rows];
   logic [addr_w-1:0] tbl_addr [max_rows];
   logic [data_w-1:0] tbl_data [max_rows];
   logic [data_w-1:0] tbl_exp  [max_rows];
   // word held before a write, for the halted storage check
   logic [data_w-1:0] tbl_prev [max_rows];
   int                tbl_halt [max_rows];
   bit                tbl_poke [max_rows];
   string             tbl_name [max_rows];
   int                n_rows;
   bit                table_ready;

   // testbench copy of both spaces
   logic [data_w-1:0] mem_shadow [mem_depth];
   logic [data_w-1:0] io_shadow  [io_depth];

   int                n_checks;
   int                n_errors;

   bus_subsystem_top #(
      .mem_wait (mem_wait),
      .io_wait  (io_wait)
   ) UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .nhalt     (nhalt),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .busy      (busy),
      .done      (done),
      .rdata     (rdata)
   );

   always #half_period clk = ~clk;

   ////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////

   // upper op bit selects i/o space, lower bit marks a write
   function automatic bit is_io(bus_op_e op);
      return (op == op_io_read) || (op == op_io_write);
   endfunction

   function automatic bit is_write(bus_op_e op);
      return (op == op_mem_write) || (op == op_io_write);
   endfunction

   // accept edge to done edge, stretched by halted cycles
   function automatic int expected_latency(bus_op_e op, int halt);
      return 2 + (is_io(op) ? io_wait : mem_wait) + halt;
   endfunction

   // peek at the target storage for the addressed word
   function automatic logic [data_w-1:0] stored_word(bus_op_e op, logic [addr_w-1:0] addr);
      if (is_io(op)) begin
         return UUT.u_target.io_regs[addr[io_aw-1:0]];
      end
      return UUT.u_target.mem[addr[mem_aw-1:0]];
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic add_row(input bus_op_e op, input logic [addr_w-1:0] addr, input int halt,
                          input bit poke, input string name);
      tbl_op[n_rows]   = op;
      tbl_addr[n_rows] = addr;
      tbl_data[n_rows] = '0;
      tbl_halt[n_rows] = halt;
      tbl_poke[n_rows] = poke;
      tbl_name[n_rows] = name;
      n_rows++;
   endtask

   task automatic build_table();
      int io_row;
      int mem_row;
      int idx;
      // write then read back, then two addresses in a row
      add_row(op_mem_write, 16'h0010, 0, 1'b0, "mem_wr_10");
      add_row(op_mem_read,  16'h0010, 0, 1'b0, "mem_rd_10");
      add_row(op_mem_write, 16'h0011, 0, 1'b0, "mem_wr_11");
      add_row(op_mem_write, 16'h00f2, 0, 1'b0, "mem_wr_f2");
      add_row(op_mem_read,  16'h0011, 0, 1'b0, "mem_rd_11");
      add_row(op_mem_read,  16'h00f2, 0, 1'b0, "mem_rd_f2");
      // same address in both spaces
      io_row = n_rows;
      add_row(op_io_write,  16'h0003, 0, 1'b0, "io_wr_3");
      mem_row = n_rows;
      add_row(op_mem_write, 16'h0003, 0, 1'b0, "mem_wr_3");
      add_row(op_io_read,   16'h0003, 0, 1'b0, "io_rd_3");
      add_row(op_mem_read,  16'h0003, 0, 1'b0, "mem_rd_3");
      add_row(op_io_write,  16'h0007, 0, 1'b0, "io_wr_7");
      add_row(op_io_read,   16'h0007, 0, 1'b0, "io_rd_7");
      // halted commands
      add_row(op_mem_write, 16'h0010, 3, 1'b0, "halt_mem_wr_10");
      add_row(op_mem_read,  16'h0010, 0, 1'b0, "mem_rd_10_new");
      add_row(op_io_read,   16'h0003, 1, 1'b0, "halt_io_rd_3");
      // second command offered while busy
      add_row(op_mem_write, 16'h0020, 0, 1'b1, "busy_poke_wr_20");
      add_row(op_mem_read,  16'h0020, 0, 1'b0, "mem_rd_20");
      add_row(op_io_write,  16'h0007, 2, 1'b0, "halt_io_wr_7");
      add_row(op_io_read,   16'h0007, 0, 1'b0, "io_rd_7_new");

      for (int i = 0; i < n_rows; i++) begin
         if (is_write(tbl_op[i])) begin
            tbl_data[i] = data_w'($urandom);
         end
      end
      // keep the two spaces' words apart
      tbl_data[mem_row] = ~tbl_data[io_row];

      // walk the table through the shadow to get expected words
      for (int i = 0; i < n_rows; i++) begin
         if (is_io(tbl_op[i])) begin
            idx = int'(tbl_addr[i][io_aw-1:0]);
            tbl_prev[i] = io_shadow[idx];
            if (is_write(tbl_op[i])) begin
               io_shadow[idx] = tbl_data[i];
            end
            tbl_exp[i] = io_shadow[idx];
         end else begin
            idx = int'(tbl_addr[i][mem_aw-1:0]);
            tbl_prev[i] = mem_shadow[idx];
            if (is_write(tbl_op[i])) begin
               mem_shadow[idx] = tbl_data[i];
            end
            tbl_exp[i] = mem_shadow[idx];
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // one table row, entered and left on a falling edge
   ////////////////////////////////////////////////////////////////////

   task automatic run_row(input int i);
      int edges;
      bit seen;
      int err_before;
      err_before = n_errors;
      edges      = 0;
      seen       = 1'b0;
      check({tbl_name[i], ": busy before issue"}, busy, 1'b0);
      cmd_valid = 1'b1;
      cmd_op    = tbl_op[i];
      cmd_addr  = tbl_addr[i];
      cmd_wdata = tbl_data[i];
      nhalt     = (tbl_halt[i] == 0);
      // accepting edge
      @(posedge clk);
      while (!seen) begin
         @(negedge clk);
         if (done) begin
            seen = 1'b1;
         end else begin
            // storage holds its old word through the halt
            if ((tbl_halt[i] > 0) && (edges <= tbl_halt[i]) && is_write(tbl_op[i])) begin
               check({tbl_name[i], ": storage while halted"},
                     stored_word(tbl_op[i], tbl_addr[i]), tbl_prev[i]);
            end
            // poke row offers a conflicting write for one edge
            cmd_valid = tbl_poke[i] && (edges == 0);
            if (cmd_valid) begin
               cmd_op    = op_mem_write;
               cmd_wdata = ~tbl_data[i];
            end
            nhalt = (edges >= tbl_halt[i]);
            @(posedge clk);
            edges++;
         end
      end
      check({tbl_name[i], ": latency"}, edges, expected_latency(tbl_op[i], tbl_halt[i]));
      check({tbl_name[i], ": busy at done"}, busy, 1'b0);
      if (!is_write(tbl_op[i])) begin
         check({tbl_name[i], ": read data"}, rdata, tbl_exp[i]);
      end
      // no second done from the ignored command
      if (tbl_poke[i]) begin
         repeat (poke_gap) begin
            @(negedge clk);
            check({tbl_name[i], ": extra done"}, done, 1'b0);
         end
      end
      $display("%-18s %s", tbl_name[i], (n_errors == err_before) ? "ok" : "mismatch");
   endtask

   ////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      nhalt     = 1'b1;
      cmd_valid = 1'b0;
      cmd_op    = op_mem_read;
      cmd_addr  = '0;
      cmd_wdata = '0;
      n_checks  = 0;
      n_errors  = 0;
      n_rows    = 0;
      void'($urandom(75396));
      build_table();
      table_ready = 1'b1;

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // idle outputs before any command
      repeat (2) begin
         @(negedge clk);
         check("reset_idle: busy", busy, 1'b0);
         check("reset_idle: done", done, 1'b0);
      end
      $display("%-18s %s", "reset_idle", (n_errors == 0) ? "ok" : "mismatch");

      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end

      $display("%0d tests, %0d checks, %0d errors", n_rows + 1, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // run limit scales with the table and its longest halt
   initial begin : watchdog
      int max_halt;
      int limit_cycles;
      wait (table_ready);
      max_halt = 0;
      for (int i = 0; i < n_rows; i++) begin
         if (tbl_halt[i] > max_halt) begin
            max_halt = tbl_halt[i];
         end
      end
      limit_cycles = n_rows * (12 + max_halt) + 8;
      repeat (limit_cycles) @(posedge clk);
      $display("run timed out after %0d clock cycles before the table finished", limit_cycles);
      $display("Test failed");
      $finish;
   end

endmodule

// ==== filelist.f ====
hw/bus_pkg.sv
hw/cpu_bus_if.sv
hw/dev_bus_if.sv
hw/bus_cmd_sequencer.sv
hw/databus.sv
hw/mem_io_target.sv
hw/bus_subsystem_top.sv
dv/tb_bus_subsystem.sv

// ==== hw/bus_cmd_sequencer.sv ====
module bus_cmd_sequencer import bus_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cmd_valid,
   input  bus_op_e           cmd_op,
   input  logic [addr_w-1:0] cmd_addr,
   input  logic [data_w-1:0] cmd_wdata,
   output logic              busy,
   output logic              done,
   output logic [data_w-1:0] rdata,
   cpu_bus_if.cpu            cpu
);

   typedef enum logic {
      st_idle,
      st_active
   } seq_state_e;

   seq_state_e        state_q;
   logic              nmem_q;
   logic              nio_q;
   logic              nr_q;
   logic              nwen_q;
   logic              done_q;
   logic [addr_w-1:0] addr_q;
   logic [data_w-1:0] wdata_q;
   logic [data_w-1:0] rdata_q;
   logic              accept;

   // a command is only looked at while idle
   assign accept = (state_q == st_idle) && cmd_valid;

   ////////////////////////////////////////////////////////////////////
   // control state and decoded levels
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= st_idle;
         nmem_q  <= 1'b1;
         nio_q   <= 1'b1;
         nr_q    <= 1'b1;
         nwen_q  <= 1'b1;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            st_idle: begin
               if (cmd_valid) begin
                  state_q <= st_active;
                  // space select from bit 1 and direction from bit 0
                  nmem_q  <= !(cmd_op inside {op_mem_read, op_mem_write});
                  nio_q   <= !(cmd_op inside {op_io_read, op_io_write});
                  nr_q    <= !(cmd_op inside {op_mem_read, op_io_read});
                  nwen_q  <= !(cmd_op inside {op_mem_write, op_io_write});
               end
            end
            st_active: begin
               // release all levels for the done cycle
               if (cpu.cycle_end) begin
                  state_q <= st_idle;
                  nmem_q  <= 1'b1;
                  nio_q   <= 1'b1;
                  nr_q    <= 1'b1;
                  nwen_q  <= 1'b1;
                  done_q  <= 1'b1;
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   // command payload held until the next acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= cmd_addr;
         wdata_q <= cmd_wdata;
      end
   end

   // read word captured at the end of the bus cycle
   always_ff @(posedge clk) begin
      if ((state_q == st_active) && cpu.cycle_end) begin
         rdata_q <= cpu.rdata;
      end
   end

   assign busy  = (state_q == st_active);
   assign done  = done_q;
   assign rdata = rdata_q;

   assign cpu.nmem  = nmem_q;
   assign cpu.nio   = nio_q;
   assign cpu.nr    = nr_q;
   assign cpu.nwen  = nwen_q;
   assign cpu.addr  = addr_q;
   assign cpu.wdata = wdata_q;

   // exactly one space selected while busy and none while idle
   a_one_space: assert property (@(posedge clk) disable iff (!rst_n)
      busy ? (cpu.nmem ^ cpu.nio) : (cpu.nmem && cpu.nio));

endmodule

// ==== hw/bus_pkg.sv ====
package bus_pkg;

   ////////////////////////////////////////////////////////////////////
   // bus widths
   ////////////////////////////////////////////////////////////////////

   // processor address and data word
   localparam int addr_w = 16;
   localparam int data_w = 16;

   // index bits used by each target space
   localparam int mem_aw = 8;
   localparam int io_aw  = 4;

   // storage depths that follow from the index bits
   localparam int mem_depth = 1 << mem_aw;
   localparam int io_depth  = 1 << io_aw;

   // wait-state counter width, holds counts 0 to 7
   localparam int wait_w = 3;

   ////////////////////////////////////////////////////////////////////
   // bus operations
   ////////////////////////////////////////////////////////////////////

   // one operation per bus cycle
   // bit 1 picks the space, bit 0 picks the direction
   typedef enum logic [1:0] {
      op_mem_read  = 2'b00,
      op_mem_write = 2'b01,
      op_io_read   = 2'b10,
      op_io_write  = 2'b11
   } bus_op_e;

endpackage

// ==== hw/bus_subsystem_top.sv ====
module bus_subsystem_top import bus_pkg::*; #(
   parameter int mem_wait = 2,
   parameter int io_wait  = 0
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              nhalt,
   input  logic              cmd_valid,
   input  bus_op_e           cmd_op,
   input  logic [addr_w-1:0] cmd_addr,
   input  logic [data_w-1:0] cmd_wdata,
   output logic              busy,
   output logic              done,
   output logic [data_w-1:0] rdata
);

   ////////////////////////////////////////////////////////////////////
   // internal buses
   ////////////////////////////////////////////////////////////////////

   // sequencer to data bus interface
   cpu_bus_if cpu_if ();

   // data bus interface to target
   dev_bus_if dev_if ();

   ////////////////////////////////////////////////////////////////////
   // blocks
   ////////////////////////////////////////////////////////////////////

   // command side
   bus_cmd_sequencer u_seq (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .busy      (busy),
      .done      (done),
      .rdata     (rdata),
      .cpu       (cpu_if.cpu)
   );

   // wait states, strobes and data steering
   databus u_databus (
      .clk   (clk),
      .rst_n (rst_n),
      .nhalt (nhalt),
      .cpu   (cpu_if.bus),
      .dev   (dev_if.master)
   );

   // storage, wait counts per space
   mem_io_target #(
      .mem_wait (mem_wait),
      .io_wait  (io_wait)
   ) u_target (
      .clk   (clk),
      .rst_n (rst_n),
      .dev   (dev_if.target)
   );

endmodule

// ==== hw/cpu_bus_if.sv ====
interface cpu_bus_if import bus_pkg::*; ();

   // space selects, active low, one at a time
   logic              nmem;
   logic              nio;

   // direction levels, active low
   logic              nr;
   logic              nwen;

   // address and write word, held for the whole cycle
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] wdata;

   // returned by the data bus side
   logic [data_w-1:0] rdata;
   // one-cycle pulse in the last cycle of a bus cycle
   logic              cycle_end;

   // sequencer side
   modport cpu (
      output nmem, nio, nr, nwen, addr, wdata,
      input  rdata, cycle_end
   );

   // data bus interface side
   modport bus (
      input  nmem, nio, nr, nwen, addr, wdata,
      output rdata, cycle_end
   );

endinterface

// ==== hw/databus.sv ====
module databus import bus_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       nhalt,
   cpu_bus_if.bus     cpu,
   dev_bus_if.master  dev
);

   logic sel_any;
   logic enabled;
   logic waiting_q;
   logic issued_q;
   logic strobe_phase;

   ////////////////////////////////////////////////////////////////////
   // bus enable and halt gating
   ////////////////////////////////////////////////////////////////////

   // a cycle is open while either space is selected
   assign sel_any = !cpu.nmem || !cpu.nio;

   // waiting also keeps the bus enabled and halt overrides everything
   assign enabled = nhalt && (sel_any || waiting_q);

   assign dev.nbusen   = !enabled;
   assign dev.nmem_sel = !(nhalt && !cpu.nmem);
   assign dev.nio_sel  = !(nhalt && !cpu.nio);

   ////////////////////////////////////////////////////////////////////
   // wait-state flip-flop and strobe phase
   ////////////////////////////////////////////////////////////////////

   // waiting_q follows the wait request sampled in an enabled cycle
   // issued_q marks that the strobe phase has passed in this cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         waiting_q <= 1'b0;
         issued_q  <= 1'b0;
      end else if (!sel_any) begin
         // selects released so the next bus cycle starts clean
         waiting_q <= 1'b0;
         issued_q  <= 1'b0;
      end else if (nhalt) begin
         if (enabled) begin
            waiting_q <= !dev.nws;
         end
         if (strobe_phase) begin
            issued_q <= 1'b1;
         end
      end
      // both flags hold their value while halted
   end

   // first enabled cycle with no wait request
   assign strobe_phase = enabled && dev.nws && !issued_q;

   // write enable gated by the not-waiting state and fired once per cycle
   assign dev.nw = !(strobe_phase && !cpu.nwen);

   // the cycle closes one clock after the strobe phase
   assign cpu.cycle_end = enabled && issued_q && !waiting_q && dev.nws;

   ////////////////////////////////////////////////////////////////////
   // data steering
   ////////////////////////////////////////////////////////////////////

   assign dev.ab = cpu.addr;

   // outbound word only on an enabled write
   assign dev.db_out = (enabled && !cpu.nwen) ? cpu.wdata : '0;

   // inbound word only on an enabled read
   assign cpu.rdata = (enabled && !cpu.nr) ? dev.db_in : '0;

   // strobe never during a wait request or a halt
   // and the flip-flop is clear and the strobe spent right after it
   a_nw_not_waiting: assert property (@(posedge clk) disable iff (!rst_n)
      !dev.nw |-> (dev.nws && nhalt) ##1 (issued_q && !waiting_q));

   // the target is not waiting when the cycle closes nor in the cycle before
   a_end_not_waiting: assert property (@(posedge clk) disable iff (!rst_n)
      cpu.cycle_end |-> (dev.nws && $past(dev.nws)));

endmodule

// ==== hw/dev_bus_if.sv ====
interface dev_bus_if import bus_pkg::*; ();

   // bus enable and space selects, all active low
   logic              nbusen;
   logic              nmem_sel;
   logic              nio_sel;

   // write strobe, low for one cycle per write
   logic              nw;

   // address bus and outbound data
   logic [addr_w-1:0] ab;
   logic [data_w-1:0] db_out;

   // inbound data and wait request from the target
   logic [data_w-1:0] db_in;
   logic              nws;

   // data bus interface side
   modport master (
      output nbusen, nmem_sel, nio_sel, nw, ab, db_out,
      input  db_in, nws
   );

   // memory and i/o target side
   modport target (
      input  nbusen, nmem_sel, nio_sel, nw, ab, db_out,
      output db_in, nws
   );

endinterface

// ==== hw/mem_io_target.sv ====
module mem_io_target import bus_pkg::*; #(
   parameter int mem_wait = 2,
   parameter int io_wait  = 0
) (
   input  logic       clk,
   input  logic       rst_n,
   dev_bus_if.target  dev
);

   // wait counts trimmed to the counter width
   localparam logic [wait_w-1:0] mem_wait_c = wait_w'(mem_wait);
   localparam logic [wait_w-1:0] io_wait_c  = wait_w'(io_wait);

   logic [data_w-1:0] mem     [mem_depth];
   logic [data_w-1:0] io_regs [io_depth];

   logic              enabled;
   logic              active_q;
   logic [wait_w-1:0] cnt_q;
   logic [wait_w-1:0] wait_sel;
   logic [wait_w-1:0] remaining;

   assign enabled = !dev.nbusen;

   ////////////////////////////////////////////////////////////////////
   // wait-state counter
   ////////////////////////////////////////////////////////////////////

   // count requested by the addressed space
   assign wait_sel = !dev.nio_sel ? io_wait_c : mem_wait_c;

   // first enabled cycle takes the full count, later ones the counter
   assign remaining = active_q ? cnt_q : wait_sel;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active_q <= 1'b0;
         cnt_q    <= '0;
      end else if (!enabled) begin
         // bus idle or halted, next enabled cycle starts over
         active_q <= 1'b0;
         cnt_q    <= '0;
      end else begin
         active_q <= 1'b1;
         if (remaining != '0) begin
            cnt_q <= remaining - 1'b1;
         end else begin
            cnt_q <= '0;
         end
      end
   end

   // request waits while count remains
   assign dev.nws = !(enabled && (remaining != '0));

   ////////////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////////////

   // written on the edge that ends the strobe cycle
   always_ff @(posedge clk) begin
      if (!dev.nw) begin
         if (!dev.nmem_sel) begin
            mem[dev.ab[mem_aw-1:0]] <= dev.db_out;
         end else if (!dev.nio_sel) begin
            io_regs[dev.ab[io_aw-1:0]] <= dev.db_out;
         end
      end
   end

   // combinational read from the selected space
   assign dev.db_in = !dev.nio_sel ? io_regs[dev.ab[io_aw-1:0]]
                                   : mem[dev.ab[mem_aw-1:0]];

   // a wait request only inside an enabled, selected cycle
   a_nws_enabled: assert property (@(posedge clk) disable iff (!rst_n)
      !dev.nws |-> (!dev.nbusen && (!dev.nmem_sel || !dev.nio_sel)));

endmodule
